/* design/yaw_pkg.sv */
// Shared types and angle constants for the yaw angle accumulator.
// Angles are in IMU counts with 4 fractional bits, so 16 counts per degree
// and 5760 counts per full turn. Receiver values are 8-bit, 0 to 250.
// Modules refer to these by scoped names.

`default_nettype none

package yaw_pkg;

	// Receiver stick or throttle value
	typedef logic [7:0] pwm_t;

	// Signed angle, or a stick-derived value, in IMU counts
	typedef logic signed [15:0] angle_t;

	// 360 degrees at 16 counts per degree
	localparam angle_t ANGLE_360 = 16'sd5760;

	localparam angle_t ANGLE_270 = 16'sd4320;

	// Flip guard and error clamp bound
	localparam angle_t ANGLE_90 = 16'sd1440;

	// Lower bound of a valid IMU angle
	localparam angle_t ANGLE_0 = 16'sd0;

endpackage

`default_nettype wire

/* design/yaw_stage_if.sv */
// Item buses between the pipeline stages of the yaw angle accumulator.
// sample_if runs from the sample stage to the heading tracker, target_if
// from the heading tracker to the error shaper. valid marks a new item and
// is high for one cycle per item.

`timescale 1ns/1ns
`default_nettype none

interface sample_if;
	logic valid;
	logic throttle_idle;
	yaw_pkg::pwm_t yaw_raw;
	// Stick relative to its neutral value
	yaw_pkg::angle_t stick;
	// IMU angle after glitch rejection
	yaw_pkg::angle_t imu;

	modport source (output valid, throttle_idle, yaw_raw, stick, imu);
	modport sink (input valid, throttle_idle, yaw_raw, stick, imu);
endinterface

interface target_if;
	logic valid;
	logic throttle_idle;
	yaw_pkg::pwm_t yaw_raw;
	yaw_pkg::angle_t imu;
	// Heading target, 0 to 360 degrees
	yaw_pkg::angle_t target;
	logic out_of_window;

	modport source (output valid, throttle_idle, yaw_raw, imu, target, out_of_window);
	modport sink (input valid, throttle_idle, yaw_raw, imu, target, out_of_window);
endinterface

`default_nettype wire

/* design/yaw_sample_stage.sv */
// First pipeline stage of the yaw angle accumulator.
// Accepts an item on every rising edge with start high. It filters out IMU
// glitches by keeping the last good angle, captures the stick neutral value
// while the throttle is idle and sends the stick relative to that neutral.
// The idle decision made here travels with the item to later stages.

`timescale 1ns/1ns
`default_nettype none

module yaw_sample_stage #(
	parameter int IDLE_THROTTLE = 10
) (
	input  wire logic            us_clk,
	input  wire logic            resetn,
	input  wire logic            start,
	input  wire yaw_pkg::pwm_t   throttle,
	input  wire yaw_pkg::pwm_t   yaw,
	input  wire yaw_pkg::angle_t yaw_angle_imu,
	sample_if.source             out
);

	localparam yaw_pkg::pwm_t IDLE_LIMIT = yaw_pkg::pwm_t'(IDLE_THROTTLE);

	yaw_pkg::pwm_t   neutral;
	yaw_pkg::angle_t last_good_imu;

	logic            idle_now;
	logic            imu_ok;
	yaw_pkg::pwm_t   neutral_next;
	yaw_pkg::angle_t imu_next;
	yaw_pkg::angle_t stick_next;

	assign idle_now = throttle < IDLE_LIMIT;
	assign imu_ok = (yaw_angle_imu >= yaw_pkg::ANGLE_0) && (yaw_angle_imu <= yaw_pkg::ANGLE_360);
	assign imu_next = imu_ok ? yaw_angle_imu : last_good_imu;

	// An idle item sees its own yaw as neutral, so its stick is zero
	assign neutral_next = idle_now ? yaw : neutral;
	assign stick_next = yaw_pkg::angle_t'({8'h00, yaw}) - yaw_pkg::angle_t'({8'h00, neutral_next});

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			out.valid     <= 1'b0;
			neutral       <= '0;
			last_good_imu <= '0;
		end else begin
			out.valid <= start;
			if (start) begin
				neutral       <= neutral_next;
				last_good_imu <= imu_next;
			end
		end
	end

	// Item payload
	always_ff @(posedge us_clk) begin
		if (start) begin
			out.throttle_idle <= idle_now;
			out.yaw_raw       <= yaw;
			out.stick         <= stick_next;
			out.imu           <= imu_next;
		end
	end

	// The filtered angle is always a legal heading, also after a glitch
	imu_in_range: assert property (@(posedge us_clk) disable iff (!resetn)
		out.valid |-> (out.imu >= yaw_pkg::ANGLE_0 && out.imu <= yaw_pkg::ANGLE_360))
		else $error("sample stage sent an IMU angle outside 0 to 360 degrees");

endmodule

`default_nettype wire

/* design/heading_tracker.sv */
// Second pipeline stage of the yaw angle accumulator.
// Integrates stick deflection into a heading target. The accumulator holds
// the heading scaled by 2^SCALE_BITS, so small deflections add up slowly,
// and wraps around one full turn. While the throttle is idle the target
// follows the IMU angle. A stick inside the neutral band holds the target.

`timescale 1ns/1ns
`default_nettype none

module heading_tracker #(
	parameter int SCALE_BITS   = 2,
	parameter int NEUTRAL_BAND = 4
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	sample_if.sink    in,
	target_if.source  out
);

	localparam int ACC_W = 16 + SCALE_BITS;

	typedef logic signed [ACC_W-1:0] acc_t;

	// One full turn in accumulator units
	localparam acc_t FULL_TURN = acc_t'(yaw_pkg::ANGLE_360) <<< SCALE_BITS;
	localparam yaw_pkg::angle_t BAND = yaw_pkg::angle_t'(NEUTRAL_BAND);

	acc_t acc;
	acc_t acc_sum;
	acc_t acc_next;
	logic in_band;
	logic oow_next;
	yaw_pkg::angle_t target_next;

	assign in_band = (in.stick > -BAND) && (in.stick < BAND);
	assign acc_sum = acc + acc_t'(in.stick);

	always_comb begin
		acc_next = acc;
		oow_next = 1'b0;
		if (in.throttle_idle) begin
			acc_next = acc_t'(in.imu) <<< SCALE_BITS;
		end else if (!in_band) begin
			oow_next = 1'b1;
			if (acc_sum > FULL_TURN)
				acc_next = acc_sum - FULL_TURN;
			else if (acc_sum < 0)
				acc_next = acc_sum + FULL_TURN;
			else
				acc_next = acc_sum;
		end
	end

	// Idle target is the IMU angle itself, otherwise the descaled heading
	assign target_next = in.throttle_idle ? in.imu : yaw_pkg::angle_t'(acc_next >>> SCALE_BITS);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			out.valid <= 1'b0;
			acc       <= '0;
		end else begin
			out.valid <= in.valid;
			if (in.valid)
				acc <= acc_next;
		end
	end

	always_ff @(posedge us_clk) begin
		if (in.valid) begin
			out.throttle_idle <= in.throttle_idle;
			out.yaw_raw       <= in.yaw_raw;
			out.imu           <= in.imu;
			out.target        <= target_next;
			out.out_of_window <= oow_next;
		end
	end

	// Wrap keeps the heading within one turn for any stick the receiver sends
	acc_in_turn: assert property (@(posedge us_clk) disable iff (!resetn)
		out.valid |-> (acc >= 0 && acc <= FULL_TURN))
		else $error("heading accumulator left the range of one full turn");

endmodule

`default_nettype wire

/* design/yaw_error_shaper.sv */
// Third pipeline stage of the yaw angle accumulator.
// Forms the heading error between target and IMU angle, taking the short
// way across 0/360 degrees. A guard holds the error at +/-90 degrees rather
// than letting it jump to the opposite sign, and the result is clamped to
// +/-90 degrees. With yaac_enable_n high the raw yaw stick passes through.
// Drives the registered results and the one-cycle complete pulse.

`timescale 1ns/1ns
`default_nettype none

module yaw_error_shaper (
	input  wire logic        us_clk,
	input  wire logic        resetn,
	input  wire logic        yaac_enable_n,
	target_if.sink           in,
	output yaw_pkg::angle_t  target_angle,
	output yaw_pkg::angle_t  angle_error,
	output logic             out_of_window,
	output logic             complete
);

	localparam yaw_pkg::angle_t A90 = yaw_pkg::ANGLE_90;

	yaw_pkg::angle_t prev_error;
	yaw_pkg::angle_t raw_error;
	yaw_pkg::angle_t guarded_error;
	yaw_pkg::angle_t clamped_error;

	always_comb begin
		if (in.throttle_idle)
			raw_error = '0;
		else if (in.target > yaw_pkg::ANGLE_270 && in.imu < A90)
			raw_error = -(yaw_pkg::ANGLE_360 - in.target + in.imu);
		else if (in.imu > yaw_pkg::ANGLE_270 && in.target < A90)
			raw_error = yaw_pkg::ANGLE_360 - in.imu + in.target;
		else
			raw_error = in.target - in.imu;
	end

	// Hold at the bound instead of flipping between +90 and -90
	always_comb begin
		if (prev_error >= A90 && raw_error <= -A90)
			guarded_error = A90;
		else if (prev_error <= -A90 && raw_error >= A90)
			guarded_error = -A90;
		else
			guarded_error = raw_error;
	end

	always_comb begin
		if (guarded_error > A90)
			clamped_error = A90;
		else if (guarded_error < -A90)
			clamped_error = -A90;
		else
			clamped_error = guarded_error;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			complete      <= 1'b0;
			prev_error    <= '0;
			target_angle  <= '0;
			angle_error   <= '0;
			out_of_window <= 1'b0;
		end else begin
			complete <= in.valid;
			if (in.valid) begin
				prev_error    <= guarded_error;
				out_of_window <= in.out_of_window;
				if (yaac_enable_n) begin
					target_angle <= yaw_pkg::angle_t'({8'h00, in.yaw_raw});
					angle_error  <= '0;
				end else begin
					target_angle <= in.target;
					angle_error  <= clamped_error;
				end
			end
		end
	end

	error_in_bound: assert property (@(posedge us_clk) disable iff (!resetn)
		complete |-> (angle_error >= -A90 && angle_error <= A90))
		else $error("angle error beyond +/-90 degrees at completion");

endmodule

`default_nettype wire

/* design/yaw_angle_accumulator.sv */
// Yaw angle accumulator top level.
// Each rising edge with start high accepts throttle, yaw and IMU angle.
// complete pulses three edges later with target_angle, angle_error and
// out_of_window for that item. Items may be sent back to back.

`timescale 1ns/1ns
`default_nettype none

module yaw_angle_accumulator #(
	parameter int SCALE_BITS    = 2,
	parameter int IDLE_THROTTLE = 10,
	parameter int NEUTRAL_BAND  = 4
) (
	input  wire logic            us_clk,
	input  wire logic            resetn,
	input  wire logic            start,
	input  wire yaw_pkg::pwm_t   throttle,
	input  wire yaw_pkg::pwm_t   yaw,
	input  wire yaw_pkg::angle_t yaw_angle_imu,
	input  wire logic            yaac_enable_n,
	output logic                 complete,
	output yaw_pkg::angle_t      target_angle,
	output yaw_pkg::angle_t      angle_error,
	output logic                 out_of_window
);

	sample_if smp ();
	target_if tgt ();

	yaw_sample_stage #(
		.IDLE_THROTTLE (IDLE_THROTTLE)
	) sample0 (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.start         (start),
		.throttle      (throttle),
		.yaw           (yaw),
		.yaw_angle_imu (yaw_angle_imu),
		.out           (smp.source)
	);

	heading_tracker #(
		.SCALE_BITS   (SCALE_BITS),
		.NEUTRAL_BAND (NEUTRAL_BAND)
	) tracker0 (
		.us_clk (us_clk),
		.resetn (resetn),
		.in     (smp.sink),
		.out    (tgt.source)
	);

	yaw_error_shaper shaper0 (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.yaac_enable_n (yaac_enable_n),
		.in            (tgt.sink),
		.target_angle  (target_angle),
		.angle_error   (angle_error),
		.out_of_window (out_of_window),
		.complete      (complete)
	);

endmodule

`default_nettype wire

/* verification/tb_yaw_angle_accumulator.sv */
// Testbench for the yaw angle accumulator.
// Drives phases of idle throttle, stick deflection with wrap, flip guard,
// back-to-back items, IMU glitches and bypass. A reference model predicts
// each item's results and concurrent assertions compare them with the DUT.

`timescale 1ns/1ns
`default_nettype none

module tb_yaw_angle_accumulator;

	localparam int N_IDLE = 4;
	localparam int N_NEUTRAL = 6;
	localparam int N_WRAP = 14;
	localparam int N_FLIP = 7;
	localparam int N_BURST = 40;
	localparam int N_GLITCH = 7;
	localparam int N_BYPASS = 8;
	localparam int N_ITEMS = N_IDLE + N_NEUTRAL + N_WRAP + N_FLIP + N_BURST + N_GLITCH + N_BYPASS;
	localparam int RESET_CYCLES = 5;
	localparam int WATCHDOG_NS = (N_ITEMS * 8 + RESET_CYCLES) * 4;
	// Full turn and its value in accumulator units (SCALE_BITS of 2)
	localparam int TURN = 5760;
	localparam int ACC_TURN = TURN * 4;

	logic us_clk;
	logic resetn;
	logic start;
	yaw_pkg::pwm_t throttle;
	yaw_pkg::pwm_t yaw;
	yaw_pkg::angle_t yaw_angle_imu;
	logic yaac_enable_n;
	logic complete;
	yaw_pkg::angle_t target_angle;
	yaw_pkg::angle_t angle_error;
	logic out_of_window;

	int seed = 32'h18e5;
	string test_name = "reset";

	// Reference model state and expected outputs
	int m_neutral, m_last_imu, m_acc, m_prev;
	int idle, imu_f, stick, acc_sum, tgt, raw, guarded, clamped, oow;
	int q_target[$], q_error[$], q_yaw[$], q_oow[$];
	int exp_target, exp_error, exp_oow;
	int in_flight;
	logic [2:0] due;

	yaw_angle_accumulator dut0 (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.start         (start),
		.throttle      (throttle),
		.yaw           (yaw),
		.yaw_angle_imu (yaw_angle_imu),
		.yaac_enable_n (yaac_enable_n),
		.complete      (complete),
		.target_angle  (target_angle),
		.angle_error   (angle_error),
		.out_of_window (out_of_window)
	);

	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	task automatic flag_mismatch(input string what, input int expected, input int actual);
		$display("mismatch in test %s on %s: expected %0d, actual %0d",
			test_name, what, expected, actual);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic int pick(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return lo + r % (hi - lo + 1);
	endfunction

	always @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			m_neutral = 0;
			m_last_imu = 0;
			m_acc = 0;
			m_prev = 0;
			in_flight = 0;
			q_target.delete();
			q_error.delete();
			q_yaw.delete();
			q_oow.delete();
			due <= '0;
			exp_target <= 0;
			exp_error <= 0;
			exp_oow <= 0;
		end else begin
			if (due[2])
				in_flight = in_flight - 1;
			// Outputs of this item become visible at the next edge
			if (due[1]) begin
				exp_oow <= q_oow.pop_front();
				if (yaac_enable_n) begin
					exp_target <= q_yaw.pop_front();
					exp_error <= 0;
					void'(q_target.pop_front());
					void'(q_error.pop_front());
				end else begin
					exp_target <= q_target.pop_front();
					exp_error <= q_error.pop_front();
					void'(q_yaw.pop_front());
				end
			end
			due <= {due[1:0], start};
			if (start) begin
				idle = throttle < 10;
				if (yaw_angle_imu >= 0 && yaw_angle_imu <= TURN)
					imu_f = yaw_angle_imu;
				else
					imu_f = m_last_imu;
				m_last_imu = imu_f;
				if (idle)
					m_neutral = yaw;
				stick = int'(yaw) - m_neutral;
				oow = 0;
				if (idle) begin
					m_acc = imu_f * 4;
					tgt = imu_f;
				end else begin
					if (stick <= -4 || stick >= 4) begin
						oow = 1;
						acc_sum = m_acc + stick;
						if (acc_sum > ACC_TURN)
							acc_sum = acc_sum - ACC_TURN;
						else if (acc_sum < 0)
							acc_sum = acc_sum + ACC_TURN;
						m_acc = acc_sum;
					end
					tgt = m_acc / 4;
				end
				if (idle)
					raw = 0;
				else if (tgt > 4320 && imu_f < 1440)
					raw = -(TURN - tgt + imu_f);
				else if (imu_f > 4320 && tgt < 1440)
					raw = TURN - imu_f + tgt;
				else
					raw = tgt - imu_f;
				if (m_prev >= 1440 && raw <= -1440)
					guarded = 1440;
				else if (m_prev <= -1440 && raw >= 1440)
					guarded = -1440;
				else
					guarded = raw;
				m_prev = guarded;
				clamped = (guarded > 1440) ? 1440 : ((guarded < -1440) ? -1440 : guarded);
				q_target.push_back(tgt);
				q_error.push_back(clamped);
				q_yaw.push_back(int'(yaw));
				q_oow.push_back(oow);
				in_flight = in_flight + 1;
			end
		end
	end

	complete_timing: assert property (@(posedge us_clk) disable iff (!resetn)
		complete == due[2])
		else flag_mismatch("complete", $sampled(due[2]), $sampled(complete));

	target_matches: assert property (@(posedge us_clk) disable iff (!resetn)
		target_angle == exp_target)
		else flag_mismatch("target_angle", $sampled(exp_target), $sampled(target_angle));

	error_matches: assert property (@(posedge us_clk) disable iff (!resetn)
		angle_error == exp_error)
		else flag_mismatch("angle_error", $sampled(exp_error), $sampled(angle_error));

	window_matches: assert property (@(posedge us_clk) disable iff (!resetn)
		out_of_window == exp_oow)
		else flag_mismatch("out_of_window", $sampled(exp_oow), $sampled(out_of_window));

	task automatic send_item(input int thr, input int yw, input int imu);
		@(posedge us_clk);
		start <= 1'b1;
		throttle <= yaw_pkg::pwm_t'(thr);
		yaw <= yaw_pkg::pwm_t'(yw);
		yaw_angle_imu <= yaw_pkg::angle_t'(imu);
	endtask

	// Stop sending and wait until every accepted item has completed
	task automatic drain_pipeline;
		@(posedge us_clk);
		start <= 1'b0;
		@(negedge us_clk);
		while (in_flight != 0)
			@(negedge us_clk);
	endtask

	task automatic set_bypass(input logic on);
		@(posedge us_clk);
		yaac_enable_n <= on;
	endtask

	task automatic random_items(input int count, input int idle_odds, input int glitch_odds);
		int i;
		int thr;
		int imu;
		for (i = 0; i < count; i++) begin
			thr = (pick(1, idle_odds) == 1) ? pick(0, 9) : pick(10, 250);
			if (pick(1, glitch_odds) == 1)
				imu = pick(0, 1) ? pick(TURN + 1, 9000) : -pick(1, 3000);
			else
				imu = pick(0, TURN);
			send_item(thr, pick(0, 250), imu);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests completed");
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		int i;
		resetn = 1'b0;
		start = 1'b0;
		throttle = '0;
		yaw = '0;
		yaw_angle_imu = '0;
		yaac_enable_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
		repeat (2) @(posedge us_clk);

		test_name = "idle_throttle";
		for (i = 0; i < N_IDLE; i++)
			send_item(pick(0, 9), pick(0, 250), pick(0, TURN));
		drain_pipeline();

		// Same yaw as the idle capture must count as neutral
		test_name = "neutral_band";
		send_item(3, 125, 1000);
		send_item(100, 125, 1200);
		send_item(100, 127, 1100);
		send_item(100, 123, 900);
		send_item(100, 129, 1000);
		send_item(100, 121, 1000);
		drain_pipeline();

		test_name = "wrap_up";
		send_item(0, 125, 5700);
		for (i = 0; i < N_WRAP / 2 - 1; i++)
			send_item(150, 250, pick(0, 400));
		drain_pipeline();

		test_name = "wrap_down";
		send_item(0, 125, 40);
		for (i = 0; i < N_WRAP / 2 - 1; i++)
			send_item(150, 0, pick(5300, TURN));
		drain_pipeline();

		// Target parked at 2000 while the IMU swings the error across 90 degrees
		test_name = "flip_guard";
		send_item(0, 125, 2000);
		send_item(100, 125, 500);
		send_item(100, 125, 3600);
		send_item(100, 125, 3600);
		send_item(100, 125, 2000);
		send_item(100, 125, 3600);
		send_item(100, 125, 500);
		drain_pipeline();

		test_name = "back_to_back";
		random_items(N_BURST, 8, 10);
		drain_pipeline();

		// Target parked near 3000, so a glitch that got through would swing the error
		test_name = "imu_glitch";
		send_item(0, 125, 3000);
		send_item(80, 200, 6000);
		send_item(80, 30, -1);
		send_item(80, 200, 5761);
		send_item(80, 30, -32768);
		send_item(80, 200, TURN);
		send_item(80, 30, 0);
		drain_pipeline();

		test_name = "bypass";
		set_bypass(1'b1);
		random_items(N_BYPASS, 4, 6);
		drain_pipeline();
		set_bypass(1'b0);
		repeat (2) @(posedge us_clk);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* yaw_angle_accumulator.f */
design/yaw_pkg.sv
design/yaw_stage_if.sv
design/yaw_sample_stage.sv
design/heading_tracker.sv
design/yaw_error_shaper.sv
design/yaw_angle_accumulator.sv
verification/tb_yaw_angle_accumulator.sv
